// ==== rv32_core.f ====
hdl/core_cfg_pkg.sv
hdl/rv32_isa_pkg.sv
hdl/fetch_ctrl.sv
hdl/fetch_counters.sv
hdl/reg_file.sv
hdl/decode.sv
hdl/alu.sv
hdl/rv32_core.sv
testbench/rv32_core_chk.sv
testbench/rv32_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rv32_core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module rv32_core_tb -f rv32_core.f -o rv32_core_sim

./obj_dir/rv32_core_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// ==== testbench/rv32_core_tb.sv ====
// testbench for the rv32 core: random latency memory, reference model and retire checks
`timescale 1ns/1ps

module rv32_core_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int N_INST      = 200;
    localparam int WATCHDOG_NS = N_INST * 10 * CLK_PERIOD + 100 * CLK_PERIOD;

    logic                   clk;
    logic                   rst_n       = 1'b0;
    logic                   exec        = 1'b0;
    logic                   imem_rvalid = 1'b0;
    rv32_isa_pkg::inst_t    imem_rdata  = '0;
    logic                   busy;
    logic                   imem_req;
    core_cfg_pkg::addr_t    imem_addr;
    logic                   ret_valid;
    core_cfg_pkg::reg_idx_t ret_rd;
    core_cfg_pkg::xlen_t    ret_value;

    // memory model and reference model state
    logic [31:0]            rng = 32'h2c32134b;
    int                     cycle_cnt;
    int                     req_cnt;
    int                     unsup_cnt;
    int                     due_q [$];
    core_cfg_pkg::xlen_t    ref_regs [0:31];

    // expected retires, written in response order
    core_cfg_pkg::reg_idx_t exp_rd_mem  [0:511];
    core_cfg_pkg::xlen_t    exp_val_mem [0:511];
    logic [8:0]             exp_wr;
    logic [8:0]             ret_idx;
    core_cfg_pkg::reg_idx_t exp_rd_head;
    core_cfg_pkg::xlen_t    exp_val_head;

    int                     ret_errs = 0;
    int                     end_errs = 0;
    int                     chk_errs;

    rv32_core UUT (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_exec        (exec),
        .o_busy        (busy),
        .o_imem_req    (imem_req),
        .o_imem_addr   (imem_addr),
        .i_imem_rvalid (imem_rvalid),
        .i_imem_rdata  (imem_rdata),
        .o_ret_valid   (ret_valid),
        .o_ret_rd      (ret_rd),
        .o_ret_value   (ret_value)
    );

    bind rv32_core rv32_core_chk u_chk (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_imem_req    (o_imem_req),
        .i_imem_addr   (o_imem_addr),
        .i_imem_rvalid (i_imem_rvalid),
        .i_ret_valid   (o_ret_valid),
        .i_busy        (o_busy)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // small register numbers so that back-to-back dependencies are common
    function automatic rv32_isa_pkg::inst_t make_inst(input logic [31:0] r1,
                                                      input logic [31:0] r2);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        logic [3:0]  kind;
        rd   = {2'b00, r1[2:0]};
        rs1  = {2'b00, r1[5:3]};
        rs2  = {2'b00, r1[8:6]};
        f3   = r1[11:9];
        kind = r1[16:13];
        imm  = r2[11:0];
        if (kind < 4'd6) begin
            if (f3 == rv32_isa_pkg::F3_SLL) begin
                imm = {7'b0, r2[4:0]};
            end else if (f3 == rv32_isa_pkg::F3_SRL_SRA) begin
                imm = {1'b0, r1[12], 5'b0, r2[4:0]};
            end
            return {imm, rs1, f3, rd, rv32_isa_pkg::OPC_OP_IMM};
        end else if (kind < 4'd13) begin
            f7 = 7'b0;
            if (r1[12] && ((f3 == rv32_isa_pkg::F3_ADD_SUB)
                        || (f3 == rv32_isa_pkg::F3_SRL_SRA))) begin
                f7 = 7'b0100000;
            end
            return {f7, rs2, rs1, f3, rd, rv32_isa_pkg::OPC_OP};
        end else if (kind < 4'd15) begin
            return {r2[31:12], rd, rv32_isa_pkg::OPC_LUI};
        end
        // load or branch opcode, fetched but never retired
        return {r2[31:7], (r2[0] ? 7'b0000011 : 7'b1100011)};
    endfunction

    // ----------------------------------------
    // reference model, straight from the rv32i definitions
    // ----------------------------------------
    function automatic core_cfg_pkg::xlen_t ref_execute(input rv32_isa_pkg::inst_t inst,
                                                        input core_cfg_pkg::xlen_t a,
                                                        input core_cfg_pkg::xlen_t rs2_val);
        logic        is_op;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [31:0] sra_val;
        // lui
        if (inst[6:0] == 7'b0110111) begin
            return {inst[31:12], 12'h000};
        end
        is_op   = (inst[6:0] == 7'b0110011);
        b       = is_op ? rs2_val : {{20{inst[31]}}, inst[31:20]};
        sh      = b[4:0];
        sra_val = $signed(a) >>> sh;
        case (inst[14:12])
            3'd0:    return (is_op && inst[30]) ? (a - b) : (a + b);
            3'd1:    return a << sh;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return inst[30] ? sra_val : (a >> sh);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // instruction memory with random latency
    // ----------------------------------------
    always @(posedge clk) begin : mem_model
        rv32_isa_pkg::inst_t inst;
        core_cfg_pkg::xlen_t value;
        logic [31:0]         r1;
        if (!rst_n) begin
            imem_rvalid <= 1'b0;
            req_cnt     <= 0;
            unsup_cnt   <= 0;
            exp_wr      <= '0;
            cycle_cnt = 0;
            due_q.delete();
            for (int i = 0; i < 32; i++) begin
                ref_regs[i] = '0;
            end
        end else begin
            cycle_cnt = cycle_cnt + 1;
            if (imem_req) begin
                rng = xorshift32(rng);
                due_q.push_back(cycle_cnt + 1 + int'(rng % 32'd6));
                req_cnt <= req_cnt + 1;
            end
            // answers leave in request order, one per cycle
            if ((due_q.size() > 0) && (due_q[0] <= cycle_cnt)) begin
                void'(due_q.pop_front());
                rng = xorshift32(rng);
                r1 = rng;
                rng = xorshift32(rng);
                inst = make_inst(r1, rng);
                imem_rvalid <= 1'b1;
                imem_rdata  <= inst;
                if ((inst[6:0] == 7'b0110011) || (inst[6:0] == 7'b0010011)
                        || (inst[6:0] == 7'b0110111)) begin
                    value = ref_execute(inst, ref_regs[inst[19:15]], ref_regs[inst[24:20]]);
                    // x0 keeps zero and reports zero
                    if (inst[11:7] == 5'd0) begin
                        value = '0;
                    end else begin
                        ref_regs[inst[11:7]] = value;
                    end
                    exp_rd_mem[exp_wr]  <= inst[11:7];
                    exp_val_mem[exp_wr] <= value;
                    exp_wr              <= exp_wr + 9'd1;
                end else begin
                    unsup_cnt <= unsup_cnt + 1;
                end
            end else begin
                imem_rvalid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            ret_idx <= '0;
        end else if (ret_valid) begin
            ret_idx <= ret_idx + 9'd1;
        end
    end

    assign exp_rd_head  = exp_rd_mem[ret_idx];
    assign exp_val_head = exp_val_mem[ret_idx];

    // ----------------------------------------
    // retire checks
    // ----------------------------------------
    a_ret_pending: assert property (@(posedge clk) disable iff (!rst_n)
        ret_valid |-> (ret_idx < exp_wr))
        else begin
            ret_errs = ret_errs + 1;
            $error("retire with no supported instruction left to match");
        end

    a_ret_rd: assert property (@(posedge clk) disable iff (!rst_n)
        ret_valid |-> (ret_rd == exp_rd_head))
        else begin
            ret_errs = ret_errs + 1;
            $error("error retire_rd: expected %0d actual %0d", exp_rd_head, ret_rd);
        end

    a_ret_value: assert property (@(posedge clk) disable iff (!rst_n)
        ret_valid |-> (ret_value == exp_val_head))
        else begin
            ret_errs = ret_errs + 1;
            $error("error retire_value: expected %h actual %h", exp_val_head, ret_value);
        end

    a_ret_x0: assert property (@(posedge clk) disable iff (!rst_n)
        (ret_valid && (ret_rd == 5'd0)) |-> (ret_value == '0))
        else begin
            ret_errs = ret_errs + 1;
            $error("error retire_x0: expected %h actual %h", 32'h0, ret_value);
        end

    // ----------------------------------------
    // run control
    // ----------------------------------------
    initial begin : run
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        exec <= 1'b1;
        while (req_cnt < N_INST) @(posedge clk);
        exec <= 1'b0;
        repeat (2) @(posedge clk);
        while (busy) @(posedge clk);
        repeat (4) @(posedge clk);

        a_ret_count: assert (ret_idx == exp_wr)
            else begin
                end_errs = end_errs + 1;
                $error("error retire_count: expected %0d actual %0d", exp_wr, ret_idx);
            end
        a_all_answered: assert (due_q.size() == 0)
            else begin
                end_errs = end_errs + 1;
                $error("requests were still unanswered after busy fell");
            end
        a_unsup_seen: assert (unsup_cnt > 0)
            else begin
                end_errs = end_errs + 1;
                $error("no unsupported opcode was delivered");
            end

        chk_errs = int'(UUT.u_chk.fail_cnt);
        $display("errors: retire %0d, protocol %0d, end of run %0d (requests %0d, retires %0d)",
                 ret_errs, chk_errs, end_errs, req_cnt, ret_idx);
        if ((ret_errs + chk_errs + end_errs) == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== testbench/rv32_core_chk.sv ====
// fetch protocol checker: credit limit, address sequence, reset and drain behavior
`timescale 1ns/1ps

module rv32_core_chk (
    input logic                i_clk,
    input logic                i_rst_n,
    input logic                i_imem_req,
    input core_cfg_pkg::addr_t i_imem_addr,
    input logic                i_imem_rvalid,
    input logic                i_ret_valid,
    input logic                i_busy
);

    // requests sent minus responses returned
    int unsigned         outstanding;
    core_cfg_pkg::addr_t next_addr;
    int unsigned         fail_cnt = 0;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            outstanding <= 32'd0;
        end else if (i_imem_req && !i_imem_rvalid) begin
            outstanding <= outstanding + 32'd1;
        end else if (!i_imem_req && i_imem_rvalid) begin
            outstanding <= outstanding - 32'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            next_addr <= core_cfg_pkg::RESET_PC;
        end else if (i_imem_req) begin
            next_addr <= next_addr + 32'd4;
        end
    end

    // ----------------------------------------
    // credit protocol
    // ----------------------------------------
    a_credit_limit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        outstanding <= core_cfg_pkg::IMEM_CREDITS)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("more requests outstanding than the memory has credits");
        end

    a_no_req_when_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (outstanding == core_cfg_pkg::IMEM_CREDITS) |-> !i_imem_req)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("request issued with no credit left");
        end

    a_fetch_addr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_imem_req |-> (i_imem_addr == next_addr))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error fetch_addr: expected %h actual %h", next_addr, i_imem_addr);
        end

    // ----------------------------------------
    // reset and drain
    // ----------------------------------------
    a_reset_quiet: assert property (@(posedge i_clk)
        $rose(i_rst_n) |-> (!i_imem_req && !i_ret_valid && !i_busy))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("request, retire or busy active right after reset");
        end

    a_drain_done: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_busy) |-> ((outstanding == 32'd0) && !i_ret_valid))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("busy dropped before all responses were back and retired");
        end

    a_idle_no_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_busy |-> !i_imem_req)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("request issued while the core is idle");
        end

endmodule

// ==== hdl/rv32_core.sv ====
// rv32i integer core top: fetch, decode, execute and retire port
`timescale 1ns/1ps

module rv32_core (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_exec,
    output logic                   o_busy,
    output logic                   o_imem_req,
    output core_cfg_pkg::addr_t    o_imem_addr,
    input  logic                   i_imem_rvalid,
    input  rv32_isa_pkg::inst_t    i_imem_rdata,
    output logic                   o_ret_valid,
    output core_cfg_pkg::reg_idx_t o_ret_rd,
    output core_cfg_pkg::xlen_t    o_ret_value
);

    // fetch
    logic fetch_en;
    logic credits_full;

    // decode to execute
    core_cfg_pkg::reg_idx_t d_rs1;
    core_cfg_pkg::reg_idx_t d_rs2;
    logic                   d_valid;
    rv32_isa_pkg::opcode_t  d_opcode;
    rv32_isa_pkg::funct3_t  d_funct3;
    logic                   d_alt;
    core_cfg_pkg::xlen_t    d_imm;
    core_cfg_pkg::reg_idx_t d_rd;
    core_cfg_pkg::xlen_t    d_op1;
    core_cfg_pkg::xlen_t    d_op2;

    // register file read data
    core_cfg_pkg::xlen_t    rf_rs1_val;
    core_cfg_pkg::xlen_t    rf_rs2_val;

    // ----------------------------------------
    // fetch
    // ----------------------------------------
    fetch_ctrl u_fetch_ctrl (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_exec         (i_exec),
        .i_credits_full (credits_full),
        .i_pipe_busy    (d_valid | o_ret_valid),
        .o_fetch_en     (fetch_en),
        .o_busy         (o_busy)
    );

    fetch_counters u_fetch_counters (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_fetch_en     (fetch_en),
        .i_imem_rvalid  (i_imem_rvalid),
        .o_imem_req     (o_imem_req),
        .o_imem_addr    (o_imem_addr),
        .o_credits_full (credits_full)
    );

    // ----------------------------------------
    // decode and register file
    // ----------------------------------------
    // read addresses straight from the response, written back by the retire register
    reg_file u_reg_file (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rs1     (i_imem_rdata[19:15]),
        .i_rs2     (i_imem_rdata[24:20]),
        .i_we      (o_ret_valid),
        .i_rd      (o_ret_rd),
        .i_wdata   (o_ret_value),
        .o_rs1_val (rf_rs1_val),
        .o_rs2_val (rf_rs2_val)
    );

    decode u_decode (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_imem_rvalid (i_imem_rvalid),
        .i_imem_rdata  (i_imem_rdata),
        .i_rs1_val     (rf_rs1_val),
        .i_rs2_val     (rf_rs2_val),
        .o_rs1         (d_rs1),
        .o_rs2         (d_rs2),
        .o_valid       (d_valid),
        .o_opcode      (d_opcode),
        .o_funct3      (d_funct3),
        .o_alt         (d_alt),
        .o_imm         (d_imm),
        .o_rd          (d_rd),
        .o_op1         (d_op1),
        .o_op2         (d_op2)
    );

    // ----------------------------------------
    // execute and retire
    // ----------------------------------------
    alu u_alu (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (d_valid),
        .i_opcode    (d_opcode),
        .i_funct3    (d_funct3),
        .i_alt       (d_alt),
        .i_imm       (d_imm),
        .i_rd        (d_rd),
        .i_op1       (d_op1),
        .i_op2       (d_op2),
        .i_rs1       (d_rs1),
        .i_rs2       (d_rs2),
        .o_ret_valid (o_ret_valid),
        .o_ret_rd    (o_ret_rd),
        .o_ret_value (o_ret_value)
    );

endmodule

// ==== hdl/alu.sv ====
// execute stage: operand forwarding, alu operations and the retire register
`timescale 1ns/1ps

module alu (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_valid,
    input  rv32_isa_pkg::opcode_t  i_opcode,
    input  rv32_isa_pkg::funct3_t  i_funct3,
    input  logic                   i_alt,
    input  core_cfg_pkg::xlen_t    i_imm,
    input  core_cfg_pkg::reg_idx_t i_rd,
    input  core_cfg_pkg::xlen_t    i_op1,
    input  core_cfg_pkg::xlen_t    i_op2,
    input  core_cfg_pkg::reg_idx_t i_rs1,
    input  core_cfg_pkg::reg_idx_t i_rs2,
    output logic                   o_ret_valid,
    output core_cfg_pkg::reg_idx_t o_ret_rd,
    output core_cfg_pkg::xlen_t    o_ret_value
);

    logic                fwd_rs1;
    logic                fwd_rs2;
    core_cfg_pkg::xlen_t op_a;
    core_cfg_pkg::xlen_t rs2_val;
    core_cfg_pkg::xlen_t op_b;
    logic [4:0]          shamt;
    core_cfg_pkg::xlen_t result;

    // ----------------------------------------
    // forwarding from the retire register
    // ----------------------------------------
    // the register file misses only the result retiring right now
    assign fwd_rs1 = o_ret_valid && (o_ret_rd != '0) && (o_ret_rd == i_rs1);
    assign fwd_rs2 = o_ret_valid && (o_ret_rd != '0) && (o_ret_rd == i_rs2);

    assign op_a    = fwd_rs1 ? o_ret_value : i_op1;
    assign rs2_val = fwd_rs2 ? o_ret_value : i_op2;
    assign op_b    = (i_opcode == rv32_isa_pkg::OPC_OP) ? rs2_val : i_imm;
    assign shamt   = op_b[4:0];

    // ----------------------------------------
    // operations
    // ----------------------------------------
    always_comb begin
        result = '0;
        if (i_opcode == rv32_isa_pkg::OPC_LUI) begin
            result = i_imm;
        end else begin
            case (i_funct3)
                rv32_isa_pkg::F3_ADD_SUB: result = i_alt ? (op_a - op_b) : (op_a + op_b);
                rv32_isa_pkg::F3_SLL:     result = op_a << shamt;
                rv32_isa_pkg::F3_SLT:     result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
                rv32_isa_pkg::F3_SLTU:    result = (op_a < op_b) ? 32'd1 : 32'd0;
                rv32_isa_pkg::F3_XOR:     result = op_a ^ op_b;
                rv32_isa_pkg::F3_SRL_SRA: begin
                    // kept apart so the signed shift stays arithmetic
                    if (i_alt) begin
                        result = $signed(op_a) >>> shamt;
                    end else begin
                        result = op_a >> shamt;
                    end
                end
                rv32_isa_pkg::F3_OR:      result = op_a | op_b;
                rv32_isa_pkg::F3_AND:     result = op_a & op_b;
                default:                  result = '0;
            endcase
        end
    end

    // ----------------------------------------
    // retire register, also the rf write port
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ret_valid <= 1'b0;
        end else begin
            o_ret_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_ret_rd    <= i_rd;
            // x0 target reports zero
            o_ret_value <= (i_rd == '0) ? '0 : result;
        end
    end

endmodule

// ==== hdl/decode.sv ====
// decode stage: field split, immediate build and operand registers
`timescale 1ns/1ps

module decode (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_imem_rvalid,
    input  rv32_isa_pkg::inst_t    i_imem_rdata,
    input  core_cfg_pkg::xlen_t    i_rs1_val,
    input  core_cfg_pkg::xlen_t    i_rs2_val,
    output core_cfg_pkg::reg_idx_t o_rs1,
    output core_cfg_pkg::reg_idx_t o_rs2,
    output logic                   o_valid,
    output rv32_isa_pkg::opcode_t  o_opcode,
    output rv32_isa_pkg::funct3_t  o_funct3,
    output logic                   o_alt,
    output core_cfg_pkg::xlen_t    o_imm,
    output core_cfg_pkg::reg_idx_t o_rd,
    output core_cfg_pkg::xlen_t    o_op1,
    output core_cfg_pkg::xlen_t    o_op2
);

    rv32_isa_pkg::opcode_t opcode;
    rv32_isa_pkg::funct3_t funct3;
    logic                  supported;
    logic                  alt;
    core_cfg_pkg::xlen_t   imm;

    // ----------------------------------------
    // field split
    // ----------------------------------------
    assign opcode = i_imem_rdata[6:0];
    assign funct3 = i_imem_rdata[14:12];

    // anything else is dropped here and never retires
    assign supported = (opcode == rv32_isa_pkg::OPC_OP)
                    || (opcode == rv32_isa_pkg::OPC_OP_IMM)
                    || (opcode == rv32_isa_pkg::OPC_LUI);

    // bit 30 of an addi immediate must not turn it into a subtract
    assign alt = i_imem_rdata[rv32_isa_pkg::F7_ALT_BIT]
              && ((opcode == rv32_isa_pkg::OPC_OP)
               || (funct3 == rv32_isa_pkg::F3_SRL_SRA));

    // u-type for lui, i-type otherwise
    always_comb begin
        if (opcode == rv32_isa_pkg::OPC_LUI) begin
            imm = {i_imem_rdata[31:12], 12'b0};
        end else begin
            imm = {{20{i_imem_rdata[31]}}, i_imem_rdata[31:20]};
        end
    end

    // ----------------------------------------
    // stage register
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_imem_rvalid && supported;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_imem_rvalid) begin
            o_opcode <= opcode;
            o_funct3 <= funct3;
            o_alt    <= alt;
            o_imm    <= imm;
            o_rd     <= i_imem_rdata[11:7];
            o_rs1    <= i_imem_rdata[19:15];
            o_rs2    <= i_imem_rdata[24:20];
            // register file values, already bypassed for a same-cycle write
            o_op1    <= i_rs1_val;
            o_op2    <= i_rs2_val;
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
// register file: 32 x 32 bit, x0 fixed at zero, write data bypassed to reads
`timescale 1ns/1ps

module reg_file (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  core_cfg_pkg::reg_idx_t i_rs1,
    input  core_cfg_pkg::reg_idx_t i_rs2,
    input  logic                   i_we,
    input  core_cfg_pkg::reg_idx_t i_rd,
    input  core_cfg_pkg::xlen_t    i_wdata,
    output core_cfg_pkg::xlen_t    o_rs1_val,
    output core_cfg_pkg::xlen_t    o_rs2_val
);

    // x1 to x31, x0 has no storage
    core_cfg_pkg::xlen_t regs [1:31];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // read port, same-cycle write wins
    function automatic core_cfg_pkg::xlen_t read_port(input core_cfg_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (i_we && (i_rd == idx)) begin
            return i_wdata;
        end
        return regs[idx];
    endfunction

    always_comb begin
        o_rs1_val = read_port(i_rs1);
        o_rs2_val = read_port(i_rs2);
    end

endmodule

// ==== hdl/fetch_counters.sv ====
// fetch counters: request credits and fetch pc for the instruction memory port
`timescale 1ns/1ps

module fetch_counters (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_fetch_en,
    input  logic                i_imem_rvalid,
    output logic                o_imem_req,
    output core_cfg_pkg::addr_t o_imem_addr,
    output logic                o_credits_full
);

    core_cfg_pkg::credit_t credits;

    // one request per cycle while enabled and a credit is left
    assign o_imem_req     = i_fetch_en && (credits != '0);
    assign o_credits_full = (credits == core_cfg_pkg::credit_t'(core_cfg_pkg::IMEM_CREDITS));

    // credit count, request and response may coincide
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            credits <= core_cfg_pkg::credit_t'(core_cfg_pkg::IMEM_CREDITS);
        end else if (o_imem_req && !i_imem_rvalid) begin
            credits <= credits - core_cfg_pkg::credit_t'(1);
        end else if (!o_imem_req && i_imem_rvalid) begin
            credits <= credits + core_cfg_pkg::credit_t'(1);
        end
    end

    // fetch pc, one word per request
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_imem_addr <= core_cfg_pkg::RESET_PC;
        end else if (o_imem_req) begin
            o_imem_addr <= o_imem_addr + 32'd4;
        end
    end

endmodule

// ==== hdl/fetch_ctrl.sv ====
// fetch control: start, run and drain sequencing that gates instruction requests
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_exec,
    input  logic i_credits_full,
    input  logic i_pipe_busy,
    output logic o_fetch_en,
    output logic o_busy
);

    core_cfg_pkg::fetch_state_t state;
    core_cfg_pkg::fetch_state_t state_nxt;

    // ----------------------------------------
    // next state
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            core_cfg_pkg::FETCH_IDLE: begin
                if (i_exec) begin
                    state_nxt = core_cfg_pkg::FETCH_RUN;
                end
            end
            core_cfg_pkg::FETCH_RUN: begin
                if (!i_exec) begin
                    state_nxt = core_cfg_pkg::FETCH_DRAIN;
                end
            end
            core_cfg_pkg::FETCH_DRAIN: begin
                // every response back and nothing left to retire
                if (i_credits_full && !i_pipe_busy) begin
                    state_nxt = core_cfg_pkg::FETCH_IDLE;
                end
            end
            default: begin
                state_nxt = core_cfg_pkg::FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= core_cfg_pkg::FETCH_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // requests only while running, busy until drained
    assign o_fetch_en = (state == core_cfg_pkg::FETCH_RUN);
    assign o_busy     = (state != core_cfg_pkg::FETCH_IDLE);

endmodule

// ==== hdl/rv32_isa_pkg.sv ====
// rv32i instruction set: opcode, funct3 and funct7 constants and field types
package rv32_isa_pkg;

    // ----------------------------------------
    // instruction field types
    // ----------------------------------------

    // full instruction word as returned by the instruction memory
    typedef logic [31:0] inst_t;

    // major opcode, bits 6:0
    typedef logic [6:0] opcode_t;

    // minor operation select, bits 14:12
    typedef logic [2:0] funct3_t;

    // ----------------------------------------
    // supported opcodes
    // ----------------------------------------

    // register-register alu ops
    localparam opcode_t OPC_OP     = 7'b0110011;

    // register-immediate alu ops
    localparam opcode_t OPC_OP_IMM = 7'b0010011;

    // load upper immediate
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // ----------------------------------------
    // funct3 encodings for OP and OP-IMM
    // ----------------------------------------
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct7 bit that turns ADD into SUB and SRL into SRA
    localparam int F7_ALT_BIT = 30;

endpackage

// ==== hdl/core_cfg_pkg.sv ====
// core configuration: data and address widths, fetch credits, reset pc, fetch states
package core_cfg_pkg;

    // data word and instruction address
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;

    // register number, x0 to x31
    typedef logic [4:0] reg_idx_t;

    // outstanding fetch credits, 0 up to IMEM_CREDITS
    typedef logic [2:0] credit_t;

    // requests the memory takes before it must answer
    localparam int unsigned IMEM_CREDITS = 4;

    // first fetch address after reset
    localparam addr_t RESET_PC = 32'h0000_0000;

    // fetch sequencing
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_RUN,
        FETCH_DRAIN
    } fetch_state_t;

endpackage
